/* src/bridge_pkg.sv */
/*
  bridge bus types and register map for the host side of the core
  all bridge traffic is synchronous to clk_74a and reads are combinational
  the command window at 0xF8xxxxxx is reserved and always reads zero
*/
`default_nettype none

package bridge_pkg;

    //////////////////////////////
    // bus widths and words
    //////////////////////////////
    localparam int unsigned bridge_w = 32;

    typedef logic [bridge_w-1:0] bridge_addr_t;
    typedef logic [bridge_w-1:0] bridge_data_t;

    // host visible register map
    typedef enum logic [bridge_w-1:0] {
        addr_debug       = 32'h0010_0004,
        addr_signed      = 32'h0030_0000,
        addr_frame_reset = 32'h00F0_0014,
        addr_frame_incr  = 32'h00F0_0018,
        addr_frame_count = 32'h2000_0000,
        // only the top byte matters here
        addr_cmd_window  = 32'hF800_0000
    } reg_addr_e;

    // value debug_value comes up with
    localparam bridge_data_t debug_reset_value = 32'h1200_5678;

    // frame counter wraps at this width
    localparam int unsigned frame_count_w = 16;
    typedef logic [frame_count_w-1:0] frame_count_t;

    //////////////////////////////
    // bundles between blocks
    //////////////////////////////
    // request from the host, wr is a one cycle strobe
    typedef struct packed {
        bridge_addr_t addr;
        logic         wr;
        bridge_data_t wr_data;
    } bridge_req_t;

    typedef struct packed {
        bridge_data_t debug_value;
        bridge_data_t signed_value;
    } ctrl_regs_t;

    // one cycle command pulses toward the frame counter
    typedef struct packed {
        logic reset_frame;
        logic incr_frame;
    } frame_cmd_t;

endpackage

`default_nettype wire

/* src/audio_pkg.sv */
/*
  audio clock constants for the I2S silence generator
  mclk is derived from the 74.25 MHz clk_74a with a fractional accumulator
  sclk_div and bits_per_channel must be powers of two
*/
`default_nettype none

package audio_pkg;

    //////////////////////////////
    // fractional mclk
    //////////////////////////////
    // accumulator width, large enough for limit plus step
    localparam int unsigned accum_w = 22;

    // step per clk_74a cycle and toggle threshold
    localparam logic [accum_w-1:0] mclk_step  = accum_w'(245760);
    localparam logic [accum_w-1:0] mclk_limit = accum_w'(742500);

    // mclk periods per sclk period
    localparam int unsigned sclk_div = 4;
    // sclk falls per lrck half period
    localparam int unsigned bits_per_channel = 32;

    // pins toward the DAC
    typedef struct packed {
        logic mclk;
        logic lrck;
        logic dac;
    } i2s_t;

endpackage

`default_nettype wire

/* src/bridge_regs.sv */
/*
  bridge write decoder with two data registers and two command pulses
  a write lands at the clk_74a edge where wr is high
  command pulses last exactly one cycle, unmapped writes are dropped
*/
`default_nettype none

module bridge_regs (
    input  wire logic                    clk_74a,
    input  wire logic                    rst_n,
    input  wire bridge_pkg::bridge_req_t req,
    output bridge_pkg::ctrl_regs_t       regs,
    output bridge_pkg::frame_cmd_t       cmd
);

    //////////////////////////////
    // data registers
    //////////////////////////////
    // both registers come up with their documented values
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            regs.debug_value  <= bridge_pkg::debug_reset_value;
            regs.signed_value <= '0;
        end else if (req.wr) begin
            case (req.addr)
                bridge_pkg::addr_debug: begin
                    regs.debug_value <= req.wr_data;
                end
                bridge_pkg::addr_signed: begin
                    regs.signed_value <= req.wr_data;
                end
                default: begin
                    // other addresses leave the data alone
                    regs <= regs;
                end
            endcase
        end
    end

    //////////////////////////////
    // command pulses
    //////////////////////////////
    // single clock domain, so a plain registered pulse
    // replaces the toggle handshake of a crossing
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            cmd <= '0;
        end else begin
            // pulses drop back after one cycle
            cmd <= '0;
            if (req.wr) begin
                case (req.addr)
                    bridge_pkg::addr_frame_reset: begin
                        cmd.reset_frame <= 1'b1;
                    end
                    bridge_pkg::addr_frame_incr: begin
                        cmd.incr_frame <= 1'b1;
                    end
                    default: begin
                        // data writes and unmapped writes
                        cmd <= '0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/frame_counter.sv */
/*
  frame counter driven by vblank and the bridge frame commands
  vblank is asynchronous and goes through a synchronizer first
  a vblank rise reaches the count at the fourth clk_74a edge
*/
`default_nettype none

module frame_counter (
    input  wire logic                   clk_74a,
    input  wire logic                   rst_n,
    input  wire logic                   vblank,
    input  wire bridge_pkg::frame_cmd_t cmd,
    output bridge_pkg::frame_count_t    frame_count
);

    // three flop synchronizer plus one flop of history
    logic [2:0] vblank_sync;
    logic       vblank_last;
    logic       vblank_rise;

    //////////////////////////////
    // vblank edge detect
    //////////////////////////////
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            vblank_sync <= '0;
            vblank_last <= 1'b0;
        end else begin
            vblank_sync <= {vblank_sync[1:0], vblank};
            vblank_last <= vblank_sync[2];
        end
    end

    // high for one cycle per rising edge
    assign vblank_rise = vblank_sync[2] & ~vblank_last;

    //////////////////////////////
    // count
    //////////////////////////////
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            frame_count <= '0;
        end else if (cmd.reset_frame) begin
            // reset command wins over everything
            frame_count <= '0;
        end else begin
            // edge and increment in one cycle add two, wraps at 16 bits
            frame_count <= frame_count
                         + bridge_pkg::frame_count_t'(vblank_rise)
                         + bridge_pkg::frame_count_t'(cmd.incr_frame);
        end
    end

endmodule

`default_nettype wire

/* src/bridge_read_mux.sv */
/*
  combinational bridge read data select
  every address outside the map reads zero, command window included
*/
`default_nettype none

module bridge_read_mux (
    input  wire bridge_pkg::bridge_addr_t addr,
    input  wire bridge_pkg::ctrl_regs_t   regs,
    input  wire bridge_pkg::frame_count_t frame_count,
    output bridge_pkg::bridge_data_t      rd_data
);

    logic in_cmd_window;

    // top byte only decides the window
    assign in_cmd_window = ({addr[31:24], 24'h0} == bridge_pkg::addr_cmd_window);

    // zero default keeps this free of latches
    always_comb begin
        rd_data = '0;
        if (!in_cmd_window) begin
            case (addr)
                bridge_pkg::addr_debug:       rd_data = regs.debug_value;
                bridge_pkg::addr_signed:      rd_data = regs.signed_value;
                // count is zero extended to the bus width
                bridge_pkg::addr_frame_count: rd_data = bridge_pkg::bridge_data_t'(frame_count);
                // command addresses are write only
                bridge_pkg::addr_frame_reset,
                bridge_pkg::addr_frame_incr:  rd_data = '0;
                default:                      rd_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/audio_clock_gen.sv */
/*
  I2S clock generator playing silence
  mclk, sclk and lrck are counters in clk_74a, not separate clock nets
  mclk averages 12.288 MHz with jitter of one clk_74a period
  sclk itself is not driven out, only its falling edges are used
*/
`default_nettype none

module audio_clock_gen (
    input  wire logic        clk_74a,
    input  wire logic        rst_n,
    output audio_pkg::i2s_t  i2s
);

    logic [audio_pkg::accum_w-1:0]                   accum;
    logic                                            mclk;
    logic [$clog2(audio_pkg::sclk_div)-1:0]          sclk_cnt;
    logic [$clog2(audio_pkg::bits_per_channel)-1:0]  lrck_cnt;
    logic                                            lrck;
    logic                                            mclk_toggle;
    logic                                            mclk_rise;
    logic                                            sclk_fall;

    //////////////////////////////
    // edge strobes
    //////////////////////////////
    // accumulator over threshold means mclk flips this edge
    assign mclk_toggle = (accum >= audio_pkg::mclk_limit);
    assign mclk_rise   = mclk_toggle & ~mclk;
    // sclk falls as its divider wraps from all ones
    assign sclk_fall   = mclk_rise & (&sclk_cnt);

    //////////////////////////////
    // counters
    //////////////////////////////
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            accum    <= '0;
            mclk     <= 1'b0;
            sclk_cnt <= '0;
            lrck_cnt <= '0;
            lrck     <= 1'b0;
        end else begin
            if (mclk_toggle) begin
                accum <= accum - audio_pkg::mclk_limit + audio_pkg::mclk_step;
                mclk  <= ~mclk;
            end else begin
                accum <= accum + audio_pkg::mclk_step;
            end

            // one sclk period per sclk_div mclk rises
            if (mclk_rise) begin
                sclk_cnt <= sclk_cnt + 1'b1;
            end

            // switch channels after the last bit of a half frame
            if (sclk_fall) begin
                lrck_cnt <= lrck_cnt + 1'b1;
                if (&lrck_cnt) begin
                    lrck <= ~lrck;
                end
            end
        end
    end

    // data line carries silence
    assign i2s = '{mclk: mclk, lrck: lrck, dac: 1'b0};

endmodule

`default_nettype wire

/* src/core_top.sv */
/*
  host facing control of the core, all in the clk_74a domain
  bridge writes are plain strobes and reads are combinational
  vblank may be asynchronous, audio outputs silence
*/
`default_nettype none

module core_top (
    input  wire logic                    clk_74a,
    input  wire logic                    rst_n,

    // bridge bus from the host
    input  wire bridge_pkg::bridge_req_t bridge,
    output bridge_pkg::bridge_data_t     bridge_rd_data,

    // frame sync from the dock
    input  wire logic                    vblank,

    // I2S pins
    output audio_pkg::i2s_t              audio
);

    bridge_pkg::ctrl_regs_t   ctrl_regs;
    bridge_pkg::frame_cmd_t   frame_cmd;
    bridge_pkg::frame_count_t frame_count;

    //////////////////////////////
    // bridge writes
    //////////////////////////////
    bridge_regs u_bridge_regs (
        .clk_74a (clk_74a),
        .rst_n   (rst_n),
        .req     (bridge),
        .regs    (ctrl_regs),
        .cmd     (frame_cmd)
    );

    //////////////////////////////
    // frame count
    //////////////////////////////
    // commands arrive as one cycle pulses
    frame_counter u_frame_counter (
        .clk_74a     (clk_74a),
        .rst_n       (rst_n),
        .vblank      (vblank),
        .cmd         (frame_cmd),
        .frame_count (frame_count)
    );

    //////////////////////////////
    // bridge reads
    //////////////////////////////
    // no read strobe, data follows the address
    bridge_read_mux u_bridge_read_mux (
        .addr        (bridge.addr),
        .regs        (ctrl_regs),
        .frame_count (frame_count),
        .rd_data     (bridge_rd_data)
    );

    //////////////////////////////
    // audio
    //////////////////////////////
    // free running, independent of the bridge
    audio_clock_gen u_audio_clock_gen (
        .clk_74a (clk_74a),
        .rst_n   (rst_n),
        .i2s     (audio)
    );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
/*
  testbench clock and reset source
  clk_74a has a period of 8 time units
  rst_n is held low for the first two rising edges
*/
`default_nettype none

module tb_clock (
    output logic clk_74a,
    output logic rst_n
);

    localparam int half_period  = 4;
    localparam int reset_cycles = 2;

    // free running clock
    initial begin
        clk_74a = 1'b0;
        forever #half_period clk_74a = ~clk_74a;
    end

    // synchronous reset released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_74a);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* bench/tb_core.sv */
/*
  testbench for core_top, bridge register map, frame counter and audio clocks
  stimulus is driven on the rising edge, responses are sampled on the falling edge
  random values come from an xorshift generator seeded with 73
  the run stops at the first error
*/
`default_nettype none

module tb_core;

    //////////////////////////////
    // test lengths
    //////////////////////////////
    localparam int rw_count     = 200;
    localparam int window_count = 50;
    localparam int frame_rounds = 40;
    localparam int audio_cycles = 20000;
    // vblank rise needs four edges to reach the count
    localparam int settle_cycles = 4;
    // upper bounds of bus steps per test
    localparam int reset_test_cycles  = 10;
    localparam int rw_test_cycles     = rw_count * 2;
    localparam int window_test_cycles = window_count * 2 + 2;
    localparam int frame_test_cycles  = frame_rounds * 20;
    localparam int watchdog_cycles    = reset_test_cycles + rw_test_cycles
                                      + window_test_cycles + frame_test_cycles
                                      + audio_cycles + 1000;
    // mclk rises per lrck toggle, 4 per sclk fall times 32 sclk falls
    localparam int rises_per_lrck = audio_pkg::sclk_div * audio_pkg::bits_per_channel;

    typedef enum logic [1:0] {chk_none, chk_data, chk_count} chk_kind_e;

    // state of the audio reference model
    typedef struct packed {
        logic [audio_pkg::accum_w-1:0] acc;
        logic                          mclk;
        logic                          lrck;
        logic [15:0]                   rises;
    } audio_model_t;

    logic                     clk_74a;
    logic                     rst_n;
    bridge_pkg::bridge_req_t  bridge;
    bridge_pkg::bridge_data_t bridge_rd_data;
    logic                     vblank;
    audio_pkg::i2s_t          audio;

    // read check that travels with the address
    chk_kind_e                chk_kind;
    bridge_pkg::bridge_data_t exp_data;
    string                    exp_name;

    // register map and frame count model
    bridge_pkg::bridge_data_t model_debug;
    bridge_pkg::bridge_data_t model_signed;
    bridge_pkg::frame_count_t model_count;
    audio_model_t             audio_model;

    logic [31:0] rng_state;
    int          errors;
    int          audio_seen;

    tb_clock u_clock (
        .clk_74a (clk_74a),
        .rst_n   (rst_n)
    );

    core_top u_dut (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .bridge         (bridge),
        .bridge_rd_data (bridge_rd_data),
        .vblank         (vblank),
        .audio          (audio)
    );

    //////////////////////////////
    // random numbers
    //////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic is_mapped(input bridge_pkg::bridge_addr_t addr);
        return (addr == bridge_pkg::addr_debug) || (addr == bridge_pkg::addr_signed)
            || (addr == bridge_pkg::addr_frame_reset) || (addr == bridge_pkg::addr_frame_incr)
            || (addr == bridge_pkg::addr_frame_count);
    endfunction

    // any address outside the map, command addresses excluded
    function automatic bridge_pkg::bridge_addr_t rand_unmapped();
        bridge_pkg::bridge_addr_t a;
        a = next_rand();
        while (is_mapped(a)) a = next_rand();
        return a;
    endfunction

    //////////////////////////////
    // reference models
    //////////////////////////////
    // read data as the register map defines it
    function automatic bridge_pkg::bridge_data_t ref_read(
        input bridge_pkg::bridge_addr_t addr,
        input bridge_pkg::bridge_data_t debug_v,
        input bridge_pkg::bridge_data_t signed_v,
        input bridge_pkg::frame_count_t count
    );
        if (addr[31:24] == 8'hF8) return '0;
        if (addr == bridge_pkg::addr_debug) return debug_v;
        if (addr == bridge_pkg::addr_signed) return signed_v;
        if (addr == bridge_pkg::addr_frame_count) return {16'h0000, count};
        return '0;
    endfunction

    // reset wins, edge and increment add up
    function automatic bridge_pkg::frame_count_t ref_count(
        input bridge_pkg::frame_count_t count,
        input logic reset_cmd,
        input logic incr_cmd,
        input logic rise
    );
        if (reset_cmd) return '0;
        return count + {15'h0, rise} + {15'h0, incr_cmd};
    endfunction

    // one clk_74a edge of the fractional mclk and lrck
    function automatic audio_model_t audio_next(input audio_model_t s);
        audio_model_t n;
        n = s;
        if (s.acc >= audio_pkg::mclk_limit) begin
            n.acc  = s.acc - audio_pkg::mclk_limit + audio_pkg::mclk_step;
            n.mclk = ~s.mclk;
            // a rise when mclk was low
            if (!s.mclk) begin
                n.rises = s.rises + 16'd1;
                if (n.rises == 16'(rises_per_lrck)) begin
                    n.rises = '0;
                    n.lrck  = ~s.lrck;
                end
            end
        end else begin
            n.acc = s.acc + audio_pkg::mclk_step;
        end
        return n;
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic fail_now(input string what);
        errors = errors + 1;
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input bridge_pkg::bridge_data_t exp,
                              input bridge_pkg::bridge_data_t act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s expected 0x%08h actual 0x%08h", name, exp, act));
    endtask

    task automatic check_count(input string name, input bridge_pkg::frame_count_t exp,
                               input bridge_pkg::frame_count_t act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s expected %0d actual %0d", name, exp, act));
    endtask

    // bits shown as mclk lrck dac
    task automatic check_i2s(input string name, input audio_pkg::i2s_t exp,
                             input audio_pkg::i2s_t act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s expected %03b actual %03b", name, exp, act));
    endtask

    //////////////////////////////
    // bus tasks
    //////////////////////////////
    task automatic bus_step(input bridge_pkg::bridge_addr_t addr, input logic wr,
                            input bridge_pkg::bridge_data_t data, input chk_kind_e kind,
                            input bridge_pkg::bridge_data_t expv, input string name);
        @(posedge clk_74a);
        bridge   <= '{addr: addr, wr: wr, wr_data: data};
        chk_kind <= kind;
        exp_data <= expv;
        exp_name <= name;
    endtask

    task automatic idle(input int n);
        repeat (n) bus_step('0, 1'b0, '0, chk_none, '0, "idle");
    endtask

    // write plus the matching model update
    task automatic write_reg(input bridge_pkg::bridge_addr_t addr,
                             input bridge_pkg::bridge_data_t data);
        bus_step(addr, 1'b1, data, chk_none, '0, "write");
        if (addr == bridge_pkg::addr_debug)
            model_debug = data;
        else if (addr == bridge_pkg::addr_signed)
            model_signed = data;
        else if (addr == bridge_pkg::addr_frame_reset)
            model_count = ref_count(model_count, 1'b0 | 1'b1, 1'b0, 1'b0);
        else if (addr == bridge_pkg::addr_frame_incr)
            model_count = ref_count(model_count, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic read_data(input bridge_pkg::bridge_addr_t addr, input string name);
        bus_step(addr, 1'b0, '0, chk_data,
                 ref_read(addr, model_debug, model_signed, model_count), name);
    endtask

    task automatic read_count(input string name);
        bus_step(bridge_pkg::addr_frame_count, 1'b0, '0, chk_count,
                 ref_read(bridge_pkg::addr_frame_count, model_debug, model_signed,
                          model_count), name);
    endtask

    // optional increment write timed to hit the count on the same edge as the rise
    task automatic vblank_pulse(input int high, input int low, input logic with_incr);
        idle(1);
        vblank <= 1'b1;
        model_count = ref_count(model_count, 1'b0, 1'b0, 1'b1);
        if (with_incr) begin
            // rise needs four edges, the increment two
            idle(1);
            write_reg(bridge_pkg::addr_frame_incr, next_rand());
        end
        idle(high);
        vblank <= 1'b0;
        idle(low);
    endtask

    //////////////////////////////
    // models and compare
    //////////////////////////////
    always @(posedge clk_74a) begin
        if (!rst_n)
            audio_model <= '0;
        else
            audio_model <= audio_next(audio_model);
    end

    // falling edge, everything settled
    always @(negedge clk_74a) begin
        case (chk_kind)
            chk_data: check_data(exp_name, exp_data, bridge_rd_data);
            chk_count: begin
                check_count(exp_name, exp_data[15:0], bridge_rd_data[15:0]);
                if (bridge_rd_data[31:16] !== 16'h0000)
                    fail_now("frame count read returned nonzero upper bits");
            end
            default: ;
        endcase
        if (rst_n) begin
            audio_seen = audio_seen + 1;
            check_i2s("audio",
                      audio_pkg::i2s_t'{mclk: audio_model.mclk, lrck: audio_model.lrck,
                                        dac: 1'b0},
                      audio);
        end
    end

    //////////////////////////////
    // watchdog
    //////////////////////////////
    initial begin
        repeat (watchdog_cycles) @(posedge clk_74a);
        fail_now($sformatf("watchdog expired after %0d cycles, tests did not finish",
                           watchdog_cycles));
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        logic [31:0]              r;
        bridge_pkg::bridge_addr_t a;
        int                       op;
        bridge   = '0;
        vblank   = 1'b0;
        chk_kind = chk_none;
        exp_data = '0;
        exp_name = "";
        rng_state  = 32'd73;
        errors     = 0;
        audio_seen = 0;
        model_debug  = bridge_pkg::debug_reset_value;
        model_signed = '0;
        model_count  = '0;

        while (rst_n !== 1'b1) @(posedge clk_74a);

        // reset values
        read_data(bridge_pkg::addr_debug, "reset debug_value");
        read_data(bridge_pkg::addr_signed, "reset signed_value");
        read_count("reset frame count");

        // data writes mixed with unmapped writes
        for (int i = 0; i < rw_count; i++) begin
            op = int'(next_rand() % 3);
            if (op == 0)
                write_reg(bridge_pkg::addr_debug, next_rand());
            else if (op == 1)
                write_reg(bridge_pkg::addr_signed, next_rand());
            else
                write_reg(rand_unmapped(), next_rand());
            r = next_rand();
            read_data(r[0] ? bridge_pkg::addr_debug : bridge_pkg::addr_signed, "data readback");
        end

        // command addresses are write only
        read_data(bridge_pkg::addr_frame_reset, "frame reset address read");
        read_data(bridge_pkg::addr_frame_incr, "frame increment address read");

        // unmapped space and the 0xF8 window
        for (int i = 0; i < window_count; i++) begin
            read_data(rand_unmapped(), "unmapped read");
            r = next_rand();
            a = {8'hF8, r[23:0]};
            read_data(a, "command window read");
        end

        // frame commands and vblank
        for (int i = 0; i < frame_rounds; i++) begin
            op = int'(next_rand() % 4);
            case (op)
                0: write_reg(bridge_pkg::addr_frame_incr, next_rand());
                1: vblank_pulse(1 + int'(next_rand() % 4), 1 + int'(next_rand() % 4), 1'b0);
                2: vblank_pulse(1 + int'(next_rand() % 4), 1 + int'(next_rand() % 4), 1'b1);
                default: begin
                    // let pending vblank edges land first
                    idle(settle_cycles);
                    write_reg(bridge_pkg::addr_frame_reset, next_rand());
                end
            endcase
            idle(settle_cycles);
            read_count("frame count");
        end
        idle(1);

        // audio is checked every cycle since reset
        wait (audio_seen >= audio_cycles);
        @(posedge clk_74a);

        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
src/bridge_pkg.sv
src/audio_pkg.sv
src/bridge_regs.sv
src/frame_counter.sv
src/bridge_read_mux.sv
src/audio_clock_gen.sv
src/core_top.sv
bench/tb_clock.sv
bench/tb_core.sv

/* run.sh */
#!/bin/sh
# build tb_core with Verilator, run it, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_core -Mdir obj_dir \
    || { echo "FAIL: build did not complete"; exit 1; }

./obj_dir/Vtb_core > sim.log 2>&1
cat sim.log

grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log || { echo "FAIL: no pass line in sim.log"; exit 1; }
echo "PASS"
